/* src.f */
hdl/cp0_pkg.sv
hdl/mmu_pkg.sv
hdl/mmu_segment.sv
hdl/tlb.sv
hdl/cp0_regs.sv
hdl/cp0_mmu_top.sv
verif/tb_cp0_mmu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= tb_cp0_mmu
FILELIST  ?= src.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/tb_cp0_mmu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cp0_mmu import cp0_pkg::*, mmu_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst;
    cp0_addr_e   rd_addr, wr_addr;
    logic [31:0] rd_data;
    logic        we;
    logic [31:0] wr_data;
    logic [5:0]  hw_int;
    exc_req_t    exc;
    logic        clear_exl, tlbwi, tlbwr, tlbr, tlbp;
    logic        status_bev, status_exl, int_allowed;
    logic [31:0] epc, ebase;
    logic [7:0]  irq_pending;
    logic [31:0] iaddr, daddr, iaddr_o, daddr_o;
    logic        inst_en, data_en, inst_uncached, data_uncached;
    logic        inst_miss, data_miss, inst_invalid, data_invalid, data_modify;
    logic [31:0] lfsr = 32'h3122_0071;
    int          checks = 0;
    int          errors = 0;

    cp0_mmu_top i_dut (
        .clk, .rst, .rd_addr_i(rd_addr), .rd_data_o(rd_data), .we_i(we),
        .wr_addr_i(wr_addr), .wr_data_i(wr_data), .hw_int_i(hw_int), .exc_i(exc),
        .clear_exl_i(clear_exl), .tlbwi_i(tlbwi), .tlbwr_i(tlbwr), .tlbr_i(tlbr),
        .tlbp_i(tlbp), .status_bev_o(status_bev), .status_exl_o(status_exl),
        .epc_o(epc), .ebase_o(ebase), .int_allowed_o(int_allowed),
        .irq_pending_o(irq_pending), .iaddr_i(iaddr), .daddr_i(daddr),
        .inst_en_i(inst_en), .data_en_i(data_en), .iaddr_o(iaddr_o), .daddr_o(daddr_o),
        .inst_uncached_o(inst_uncached), .data_uncached_o(data_uncached),
        .inst_miss_o(inst_miss), .data_miss_o(data_miss), .inst_invalid_o(inst_invalid),
        .data_invalid_o(data_invalid), .data_modify_o(data_modify)
    );

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic write_reg(input cp0_addr_e a, input logic [31:0] d);
        @(posedge clk);
        we      <= 1'b1;
        wr_addr <= a;
        wr_data <= d;
        @(posedge clk);
        we <= 1'b0;
    endtask

    task automatic read_reg(input cp0_addr_e a, output logic [31:0] d);
        @(posedge clk);
        rd_addr <= a;
        @(negedge clk);
        d = rd_data;
    endtask

    task automatic strobe_tlb(input logic [3:0] ops); // Order is tlbwi, tlbwr, tlbr, tlbp
        @(posedge clk);
        {tlbwi, tlbwr, tlbr, tlbp} <= ops;
        @(posedge clk);
        {tlbwi, tlbwr, tlbr, tlbp} <= 4'b0;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        cp0_addr_e   regs_a [17];
        logic [31:0] init_v [17];
        logic [31:0] mask_v [17];
        exc_code_e   codes [4];
        logic [18:0] e_vpn2 [8];
        logic [31:0] e_hi [8];
        logic [31:0] e_lo0 [8];
        logic [31:0] e_lo1 [8];
        logic [31:0] v, old, nw, ign, b, e, im, sw, off;
        exc_code_e   code;
        int          t, r, w;

        regs_a = '{CP0_INDEX, CP0_RANDOM, CP0_ENTRYLO0, CP0_ENTRYLO1, CP0_CONTEXT,
                   CP0_PAGEMASK, CP0_WIRED, CP0_BADVADDR, CP0_ENTRYHI, CP0_COMPARE,
                   CP0_STATUS, CP0_CAUSE, CP0_EPC, CP0_PRID, CP0_EBASE, CP0_CONFIG0,
                   CP0_CONFIG1};
        init_v = '{32'h0, 32'h7, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
                   INIT_STATUS, 32'h0, 32'h0, INIT_PRID, INIT_EBASE, INIT_CONF0, INIT_CONF1};
        mask_v = '{MASK_INDEX, 32'h0, MASK_ENTRYLO0, MASK_ENTRYLO1, MASK_CONTEXT,
                   MASK_PAGEMASK, MASK_WIRED, 32'h0, MASK_ENTRYHI, MASK_COMPARE,
                   MASK_STATUS, MASK_CAUSE, MASK_EPC, 32'h0, MASK_EBASE, MASK_CONF0, 32'h0};
        codes  = '{EXC_SYS, EXC_BP, EXC_RI, EXC_OV};
        rst = 1'b1;
        rd_addr = CP0_INDEX;
        wr_addr = CP0_INDEX;
        we = 1'b0;
        wr_data = '0;
        hw_int = '0;
        exc = '0;
        clear_exl = 1'b0;
        {tlbwi, tlbwr, tlbr, tlbp} = 4'b0;
        iaddr = '0;
        daddr = '0;
        inst_en = 1'b0;
        data_en = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Count == Compare right after reset, so TI and IP7 of Cause are left out
        for (int i = 0; i < 17; i++) begin
            ign = (regs_a[i] == CP0_CAUSE) ? 32'hBFFF_7FFF : 32'hFFFF_FFFF;
            read_reg(regs_a[i], v);
            check(regs_a[i].name(), v & ign, init_v[i] & ign);
        end
        check("status_bev_o", {31'b0, status_bev}, 32'h1);
        check("ebase_o", ebase, INIT_EBASE);
        for (int i = 0; i < 17; i++) begin
            ign = (regs_a[i] == CP0_CAUSE) ? 32'hBFFF_7FFF : 32'hFFFF_FFFF;
            read_reg(regs_a[i], old);
            nw = rand_bits(32);
            write_reg(regs_a[i], nw);
            read_reg(regs_a[i], v);
            check(regs_a[i].name(), v & ign, ((old & ~mask_v[i]) | (nw & mask_v[i])) & ign);
        end
        report_test("reset and write masks");

        write_reg(CP0_STATUS, 32'h0040_0001);
        e    = rand_bits(32);
        b    = rand_bits(32);
        v    = rand_bits(2);
        code = codes[v[1:0]];
        @(posedge clk);
        exc <= '{valid: 1'b1, bd: 1'b1, epc: e, code: code, badvaddr: b, badvaddr_we: 1'b1};
        @(negedge clk);
        check("int_allowed_o", {31'b0, int_allowed}, 32'h0);
        @(posedge clk);
        exc.valid <= 1'b0;
        read_reg(CP0_EPC, v);
        check("EPC", v, e);
        check("epc_o", epc, e);
        check("status_exl_o", {31'b0, status_exl}, 32'h1);
        check("int_allowed_o", {31'b0, int_allowed}, 32'h0);
        read_reg(CP0_CAUSE, v);
        check("Cause.ExcCode", {27'b0, v[6:2]}, {27'b0, code});
        check("Cause.BD", {31'b0, v[31]}, 32'h1);
        read_reg(CP0_BADVADDR, v);
        check("BadVAddr", v, b);
        read_reg(CP0_CONTEXT, v);
        check("Context.BadVPN2", {13'b0, v[22:4]}, {13'b0, b[31:13]});
        read_reg(CP0_ENTRYHI, v);
        check("EntryHi.VPN2", {13'b0, v[31:13]}, {13'b0, b[31:13]});
        @(posedge clk);
        clear_exl <= 1'b1;
        @(posedge clk);
        clear_exl <= 1'b0;
        @(negedge clk);
        check("status_exl_o", {31'b0, status_exl}, 32'h0);
        report_test("exception entry and return");

        write_reg(CP0_CAUSE, 32'h0);
        write_reg(CP0_STATUS, 32'h0040_8001); // IE and IM7
        read_reg(CP0_COUNT, v);
        write_reg(CP0_COMPARE, v + 32'd4);
        t = 0;
        while (!irq_pending[7] && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (t >= 200) begin
            $display("Timer interrupt did not rise before the timeout");
            errors++;
        end
        read_reg(CP0_COUNT, v);
        write_reg(CP0_COMPARE, v + 32'd1000);
        @(negedge clk);
        check("irq_pending_o[7]", {31'b0, irq_pending[7]}, 32'h0);
        nw = rand_bits(6);
        im = rand_bits(8);
        sw = rand_bits(2);
        write_reg(CP0_CAUSE, {22'b0, sw[1:0], 8'b0});
        write_reg(CP0_STATUS, {16'h0040, im[7:0], 8'h00});
        @(posedge clk);
        hw_int <= nw[5:0];
        @(negedge clk);
        check("irq_pending_o", {24'b0, irq_pending}, {24'b0, im[7:0] & {nw[5:0], sw[1:0]}});
        @(posedge clk);
        hw_int <= '0;
        report_test("timer and interrupts");

        for (int k = 2; k < 4; k++) begin
            write_reg(CP0_CONFIG0, k);
            repeat (6) begin
                v  = rand_bits(30);
                nw = rand_bits(30);
                @(posedge clk);
                iaddr   <= {2'b10, v[29:0]};
                daddr   <= {2'b10, nw[29:0]};
                inst_en <= 1'b1;
                data_en <= 1'b1;
                @(negedge clk);
                check("iaddr_o", iaddr_o, {3'b000, v[28:0]});
                check("daddr_o", daddr_o, {3'b000, nw[28:0]});
                check("inst_uncached_o", {31'b0, inst_uncached}, {31'b0, v[29] | (k == 2)});
                check("data_uncached_o", {31'b0, data_uncached}, {31'b0, nw[29] | (k == 2)});
                check("exception flags", {27'b0, inst_miss, data_miss, inst_invalid,
                      data_invalid, data_modify}, 32'h0);
            end
        end
        report_test("unmapped segments");

        for (int i = 0; i < 8; i++) begin
            v         = rand_bits(13);
            e_vpn2[i] = {3'b000, v[12:0], i[2:0]};
            e_hi[i]   = {e_vpn2[i], 5'b0, (i == 7) ? 8'h33 : 8'h5A};
            v         = rand_bits(20);
            e_lo0[i]  = {6'b0, v[19:0], (i == 3) ? 3'd2 : 3'd3, 2'b11, i == 7};
            v         = rand_bits(20);
            e_lo1[i]  = {6'b0, v[19:0], 3'd3, i != 2, i != 1, i == 7};
            write_reg(CP0_INDEX, i);
            write_reg(CP0_ENTRYHI, e_hi[i]);
            write_reg(CP0_ENTRYLO0, e_lo0[i]);
            write_reg(CP0_ENTRYLO1, e_lo1[i]);
            strobe_tlb(4'b1000);
        end
        write_reg(CP0_ENTRYHI, 32'h0000_005A);
        for (int i = 0; i < 8; i++) begin
            off = rand_bits(12);
            @(posedge clk);
            iaddr <= {e_vpn2[i], 1'b0, off[11:0]};
            daddr <= {e_vpn2[i], 1'b1, off[11:0]};
            @(negedge clk);
            check("iaddr_o", iaddr_o, {e_lo0[i][25:6], off[11:0]});
            check("daddr_o", daddr_o, {e_lo1[i][25:6], off[11:0]});
            check("inst_uncached_o", {31'b0, inst_uncached}, {31'b0, i == 3});
            check("inst flags", {30'b0, inst_miss, inst_invalid}, 32'h0);
            check("data flags", {29'b0, data_miss, data_invalid, data_modify},
                  {29'b0, 1'b0, i == 1, i == 2});
        end
        @(posedge clk);
        iaddr <= {e_vpn2[1], 1'b1, 12'h0}; // Odd half of entry 1 has V clear
        @(negedge clk);
        check("inst_invalid_o", {31'b0, inst_invalid}, 32'h1);
        v  = rand_bits(29);
        nw = rand_bits(29);
        @(posedge clk);
        iaddr <= {3'b110, v[28:0]}; // No entry lies in ksseg or kseg3
        daddr <= {3'b111, nw[28:0]};
        @(negedge clk);
        check("inst_miss_o", {31'b0, inst_miss}, 32'h1);
        check("data_miss_o", {31'b0, data_miss}, 32'h1);
        write_reg(CP0_ENTRYHI, 32'h0000_0077);
        @(posedge clk);
        iaddr <= {e_vpn2[0], 13'h0};
        daddr <= {e_vpn2[7], 13'h0};
        @(negedge clk);
        check("inst_miss_o", {31'b0, inst_miss}, 32'h1);
        check("data_miss_o", {31'b0, data_miss}, 32'h0);
        check("daddr_o", daddr_o, {e_lo0[7][25:6], 12'h0});
        write_reg(CP0_ENTRYHI, {e_vpn2[5], 13'h5A});
        strobe_tlb(4'b0001);
        read_reg(CP0_INDEX, v);
        check("Index", v, 32'h5);
        write_reg(CP0_ENTRYHI, 32'hFFFF_E05A);
        strobe_tlb(4'b0001);
        read_reg(CP0_INDEX, v);
        check("Index", v, 32'h8000_0000);
        write_reg(CP0_INDEX, 32'h4);
        write_reg(CP0_ENTRYHI, 32'h0);
        write_reg(CP0_ENTRYLO0, 32'h0);
        write_reg(CP0_ENTRYLO1, 32'h0);
        strobe_tlb(4'b0010);
        read_reg(CP0_ENTRYHI, v);
        check("EntryHi", v, e_hi[4]);
        read_reg(CP0_ENTRYLO0, v);
        check("EntryLo0", v, e_lo0[4]);
        read_reg(CP0_ENTRYLO1, v);
        check("EntryLo1", v, e_lo1[4]);
        report_test("TLB write and lookup");

        v = rand_bits(2);
        w = v + 2;
        write_reg(CP0_WIRED, w);
        r = 7;
        repeat (12) begin
            strobe_tlb(4'b0100);
            r = (r + 1) % 8;
            if (r < w) begin
                r = w;
            end
            read_reg(CP0_RANDOM, v);
            check("Random", v, r);
        end
        report_test("Random and Wired");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/cp0_mmu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_mmu_top import cp0_pkg::*, mmu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire cp0_addr_e   rd_addr_i,
    output logic [31:0]      rd_data_o,
    input  wire logic        we_i,
    input  wire cp0_addr_e   wr_addr_i,
    input  wire logic [31:0] wr_data_i,
    input  wire logic [5:0]  hw_int_i,
    input  wire exc_req_t    exc_i,
    input  wire logic        clear_exl_i,
    input  wire logic        tlbwi_i,
    input  wire logic        tlbwr_i,
    input  wire logic        tlbr_i,
    input  wire logic        tlbp_i,
    output logic             status_bev_o,
    output logic             status_exl_o,
    output logic [31:0]      epc_o,
    output logic [31:0]      ebase_o,
    output logic             int_allowed_o,
    output logic [7:0]       irq_pending_o,
    input  wire logic [31:0] iaddr_i,
    input  wire logic [31:0] daddr_i,
    input  wire logic        inst_en_i,
    input  wire logic        data_en_i,
    output logic [31:0]      iaddr_o,
    output logic [31:0]      daddr_o,
    output logic             inst_uncached_o,
    output logic             data_uncached_o,
    output logic             inst_miss_o,
    output logic             data_miss_o,
    output logic             inst_invalid_o,
    output logic             data_invalid_o,
    output logic             data_modify_o
);

    tlb_entry_t           tlb_wr, tlb_rd;
    logic                 tlb_we;
    logic [TLB_IDX_W-1:0] tlb_widx, tlb_ridx;
    logic [31:0]          tlb_probe;
    logic [7:0]           asid;
    logic [2:0]           k0;
    seg_result_t          iseg, dseg;
    tlb_result_t          ires, dres;
    logic                 imap, dmap;

    cp0_regs i_regs (
        .clk, .rst, .rd_addr_i, .rd_data_o, .we_i, .wr_addr_i, .wr_data_i,
        .hw_int_i, .exc_i, .clear_exl_i, .tlbwi_i, .tlbwr_i, .tlbr_i, .tlbp_i,
        .tlb_rd_i(tlb_rd), .tlb_probe_i(tlb_probe), .tlb_we_o(tlb_we),
        .tlb_widx_o(tlb_widx), .tlb_wr_o(tlb_wr), .tlb_ridx_o(tlb_ridx),
        .asid_o(asid), .k0_o(k0), .status_bev_o, .status_exl_o, .epc_o, .ebase_o,
        .int_allowed_o, .irq_pending_o
    );

    mmu_segment i_seg_inst (.vaddr_i(iaddr_i), .k0_i(k0), .seg_o(iseg));
    mmu_segment i_seg_data (.vaddr_i(daddr_i), .k0_i(k0), .seg_o(dseg));

    tlb i_tlb (
        .clk, .rst, .we_i(tlb_we), .widx_i(tlb_widx), .wentry_i(tlb_wr),
        .ridx_i(tlb_ridx), .rentry_o(tlb_rd), .asid_i(asid),
        .probe_vpn2_i(tlb_wr.vpn2), .probe_o(tlb_probe), // Probe uses EntryHi VPN2
        .va0_i(iaddr_i), .res0_o(ires), .va1_i(daddr_i), .res1_o(dres)
    );

    assign imap = iseg.mapped;
    assign dmap = dseg.mapped;

    assign iaddr_o = imap ? {ires.pfn, iaddr_i[11:0]} : iseg.paddr;
    assign daddr_o = dmap ? {dres.pfn, daddr_i[11:0]} : dseg.paddr;

    assign inst_uncached_o = iseg.uncached | (imap & ires.uncached);
    assign data_uncached_o = dseg.uncached | (dmap & dres.uncached);

    assign inst_miss_o    = inst_en_i & imap & ires.miss;
    assign data_miss_o    = data_en_i & dmap & dres.miss;
    assign inst_invalid_o = inst_en_i & imap & ~ires.miss & ~ires.valid;
    assign data_invalid_o = data_en_i & dmap & ~dres.miss & ~dres.valid;
    assign data_modify_o  = data_en_i & dmap & ~dres.miss & dres.valid & ~dres.dirty;

endmodule

`default_nettype wire

/* hdl/cp0_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_regs import cp0_pkg::*, mmu_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire cp0_addr_e            rd_addr_i,
    output logic [31:0]               rd_data_o,
    input  wire logic                 we_i,
    input  wire cp0_addr_e            wr_addr_i,
    input  wire logic [31:0]          wr_data_i,
    input  wire logic [5:0]           hw_int_i,
    input  wire exc_req_t             exc_i,
    input  wire logic                 clear_exl_i,
    input  wire logic                 tlbwi_i,
    input  wire logic                 tlbwr_i,
    input  wire logic                 tlbr_i,
    input  wire logic                 tlbp_i,
    input  wire tlb_entry_t           tlb_rd_i,
    input  wire logic [31:0]          tlb_probe_i,
    output logic                      tlb_we_o,
    output logic [TLB_IDX_W-1:0]      tlb_widx_o,
    output tlb_entry_t                tlb_wr_o,
    output logic [TLB_IDX_W-1:0]      tlb_ridx_o,
    output logic [7:0]                asid_o,
    output logic [2:0]                k0_o,
    output logic                      status_bev_o,
    output logic                      status_exl_o,
    output logic [31:0]               epc_o,
    output logic [31:0]               ebase_o,
    output logic                      int_allowed_o,
    output logic [7:0]                irq_pending_o
);

    localparam logic [31:0] RANDOM_TOP = 32'(TLB_ENTRIES - 1);

    logic [31:0] index_q, random_q, entrylo0_q, entrylo1_q, context_q, pagemask_q;
    logic [31:0] wired_q, badvaddr_q, count_q, entryhi_q, compare_q, status_q;
    logic [31:0] cause_q, epc_q, ebase_q, conf0_q;
    logic        ti_q;
    logic        count_tick_q;
    logic [7:0]  cause_ip;
    logic [31:0] cause_rd;
    logic [TLB_IDX_W-1:0] next_random;

    function automatic logic [31:0] wmask(input logic [31:0] old_v,
                                          input logic [31:0] new_v,
                                          input logic [31:0] mask);
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    assign cause_ip = {hw_int_i[5] | ti_q, hw_int_i[4:0], cause_q[9:8]}; // Timer shares IP7
    assign cause_rd = {cause_q[31], ti_q, cause_q[29:16], cause_ip, cause_q[7:0]};

    assign irq_pending_o = status_q[15:8] & cause_ip;
    assign int_allowed_o = status_q[0] & ~status_q[1] & ~status_q[2] & ~exc_i.valid;
    assign status_bev_o  = status_q[22];
    assign status_exl_o  = status_q[1];
    assign epc_o         = epc_q;
    assign ebase_o       = ebase_q;
    assign asid_o        = entryhi_q[7:0];
    assign k0_o          = conf0_q[2:0];

    assign tlb_we_o    = tlbwi_i | tlbwr_i;
    assign tlb_widx_o  = tlbwr_i ? random_q[TLB_IDX_W-1:0] : index_q[TLB_IDX_W-1:0];
    assign tlb_ridx_o  = index_q[TLB_IDX_W-1:0];
    assign next_random = random_q[TLB_IDX_W-1:0] + 1'b1; // Wraps modulo the TLB size

    always_comb begin
        tlb_wr_o.vpn2 = entryhi_q[31:13];
        tlb_wr_o.asid = entryhi_q[7:0];
        tlb_wr_o.g    = entrylo0_q[0] & entrylo1_q[0]; // Global only when both halves agree
        tlb_wr_o.mask = pagemask_q[28:13];
        tlb_wr_o.pfn0 = entrylo0_q[25:6];
        tlb_wr_o.c0   = entrylo0_q[5:3];
        tlb_wr_o.d0   = entrylo0_q[2];
        tlb_wr_o.v0   = entrylo0_q[1];
        tlb_wr_o.pfn1 = entrylo1_q[25:6];
        tlb_wr_o.c1   = entrylo1_q[5:3];
        tlb_wr_o.d1   = entrylo1_q[2];
        tlb_wr_o.v1   = entrylo1_q[1];
    end

    always_comb begin
        case (rd_addr_i)
            CP0_INDEX:    rd_data_o = index_q;
            CP0_RANDOM:   rd_data_o = random_q;
            CP0_ENTRYLO0: rd_data_o = entrylo0_q;
            CP0_ENTRYLO1: rd_data_o = entrylo1_q;
            CP0_CONTEXT:  rd_data_o = context_q;
            CP0_PAGEMASK: rd_data_o = pagemask_q;
            CP0_WIRED:    rd_data_o = wired_q;
            CP0_BADVADDR: rd_data_o = badvaddr_q;
            CP0_COUNT:    rd_data_o = count_q;
            CP0_ENTRYHI:  rd_data_o = entryhi_q;
            CP0_COMPARE:  rd_data_o = compare_q;
            CP0_STATUS:   rd_data_o = status_q;
            CP0_CAUSE:    rd_data_o = cause_rd;
            CP0_EPC:      rd_data_o = epc_q;
            CP0_PRID:     rd_data_o = INIT_PRID;
            CP0_EBASE:    rd_data_o = ebase_q;
            CP0_CONFIG0:  rd_data_o = conf0_q;
            CP0_CONFIG1:  rd_data_o = INIT_CONF1;
            default:      rd_data_o = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index_q      <= 32'h0;
            random_q     <= RANDOM_TOP;
            entrylo0_q   <= 32'h0;
            entrylo1_q   <= 32'h0;
            context_q    <= 32'h0;
            pagemask_q   <= 32'h0;
            wired_q      <= 32'h0;
            badvaddr_q   <= 32'h0;
            count_q      <= 32'h0;
            entryhi_q    <= 32'h0;
            compare_q    <= 32'h0;
            status_q     <= INIT_STATUS;
            cause_q      <= 32'h0;
            epc_q        <= 32'h0;
            ebase_q      <= INIT_EBASE;
            conf0_q      <= INIT_CONF0;
            ti_q         <= 1'b0;
            count_tick_q <= 1'b0;
        end else begin
            count_tick_q <= ~count_tick_q;
            count_q      <= count_q + {31'd0, count_tick_q};
            if (count_q == compare_q) begin
                ti_q <= 1'b1;
            end
            if (we_i) begin
                case (wr_addr_i)
                    CP0_INDEX:    index_q    <= wmask(index_q, wr_data_i, MASK_INDEX);
                    CP0_ENTRYLO0: entrylo0_q <= wmask(entrylo0_q, wr_data_i, MASK_ENTRYLO0);
                    CP0_ENTRYLO1: entrylo1_q <= wmask(entrylo1_q, wr_data_i, MASK_ENTRYLO1);
                    CP0_CONTEXT:  context_q  <= wmask(context_q, wr_data_i, MASK_CONTEXT);
                    CP0_PAGEMASK: pagemask_q <= wmask(pagemask_q, wr_data_i, MASK_PAGEMASK);
                    CP0_WIRED: begin
                        wired_q  <= wmask(wired_q, wr_data_i, MASK_WIRED);
                        random_q <= RANDOM_TOP;
                    end
                    CP0_COUNT:    count_q    <= wmask(count_q, wr_data_i, MASK_COUNT);
                    CP0_ENTRYHI:  entryhi_q  <= wmask(entryhi_q, wr_data_i, MASK_ENTRYHI);
                    CP0_COMPARE: begin
                        compare_q <= wmask(compare_q, wr_data_i, MASK_COMPARE);
                        ti_q      <= (wr_data_i == count_q);
                    end
                    CP0_STATUS:   status_q   <= wmask(status_q, wr_data_i, MASK_STATUS);
                    CP0_CAUSE:    cause_q    <= wmask(cause_q, wr_data_i, MASK_CAUSE);
                    CP0_EPC:      epc_q      <= wmask(epc_q, wr_data_i, MASK_EPC);
                    CP0_EBASE:    ebase_q    <= wmask(ebase_q, wr_data_i, MASK_EBASE);
                    CP0_CONFIG0:  conf0_q    <= wmask(conf0_q, wr_data_i, MASK_CONF0);
                    default: ;
                endcase
            end else begin
                if (tlbr_i) begin
                    entryhi_q  <= {tlb_rd_i.vpn2, 5'b0, tlb_rd_i.asid};
                    entrylo0_q <= {6'b0, tlb_rd_i.pfn0, tlb_rd_i.c0, tlb_rd_i.d0,
                                   tlb_rd_i.v0, tlb_rd_i.g};
                    entrylo1_q <= {6'b0, tlb_rd_i.pfn1, tlb_rd_i.c1, tlb_rd_i.d1,
                                   tlb_rd_i.v1, tlb_rd_i.g};
                    pagemask_q <= {3'b0, tlb_rd_i.mask, 13'b0};
                end
                if (tlbp_i) begin
                    index_q <= tlb_probe_i;
                end
                if (tlbwr_i) begin
                    if (next_random < wired_q[TLB_IDX_W-1:0]) begin
                        random_q <= wired_q;
                    end else begin
                        random_q <= {{(32 - TLB_IDX_W){1'b0}}, next_random};
                    end
                end
                if (exc_i.valid) begin
                    if (exc_i.badvaddr_we) begin
                        badvaddr_q        <= exc_i.badvaddr;
                        context_q[22:4]   <= exc_i.badvaddr[31:13];
                        entryhi_q[31:13]  <= exc_i.badvaddr[31:13];
                    end
                    cause_q[31]  <= exc_i.bd;
                    cause_q[6:2] <= exc_i.code;
                    epc_q        <= exc_i.epc;
                    status_q[1]  <= 1'b1;
                end
            end
            if (clear_exl_i) begin
                status_q[1] <= 1'b0; // Return from exception wins over a new entry
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/tlb.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb import mmu_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 we_i,
    input  wire logic [TLB_IDX_W-1:0] widx_i,
    input  wire tlb_entry_t           wentry_i,
    input  wire logic [TLB_IDX_W-1:0] ridx_i,
    output tlb_entry_t                rentry_o,
    input  wire logic [7:0]           asid_i,
    input  wire logic [18:0]          probe_vpn2_i,
    output logic [31:0]               probe_o,
    input  wire logic [31:0]          va0_i,
    output tlb_result_t               res0_o,
    input  wire logic [31:0]          va1_i,
    output tlb_result_t               res1_o
);

    tlb_entry_t mem [TLB_ENTRIES];

    function automatic logic entry_hit(input tlb_entry_t e,
                                       input logic [18:0] vpn2,
                                       input logic [7:0]  asid);
        return (e.vpn2 == vpn2) && (e.g || (e.asid == asid));
    endfunction

    // Pages are fixed at 4 KB, so bit 12 picks the even or odd half
    function automatic tlb_result_t lookup(input logic [31:0] va);
        tlb_result_t r;
        r      = '0;
        r.miss = 1'b1;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_hit(mem[i], va[31:13], asid_i)) begin
                r.miss = 1'b0;
                if (va[12]) begin
                    r.pfn      = mem[i].pfn1;
                    r.valid    = mem[i].v1;
                    r.dirty    = mem[i].d1;
                    r.uncached = (mem[i].c1 == CACHE_UNCACHED);
                end else begin
                    r.pfn      = mem[i].pfn0;
                    r.valid    = mem[i].v0;
                    r.dirty    = mem[i].d0;
                    r.uncached = (mem[i].c0 == CACHE_UNCACHED);
                end
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                mem[i].v0 <= 1'b0;
                mem[i].v1 <= 1'b0;
            end
        end else if (we_i) begin
            mem[widx_i] <= wentry_i;
        end
    end

    always_comb begin
        res0_o = lookup(va0_i);
    end

    always_comb begin
        res1_o = lookup(va1_i);
    end

    always_comb begin
        probe_o = 32'h8000_0000; // Probe failure unless an entry matches
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_hit(mem[i], probe_vpn2_i, asid_i)) begin
                probe_o = {{(32 - TLB_IDX_W){1'b0}}, TLB_IDX_W'(i)};
            end
        end
    end

    assign rentry_o = mem[ridx_i];

endmodule

`default_nettype wire

/* hdl/mmu_segment.sv */
`timescale 1ns/1ns
`default_nettype none

module mmu_segment import mmu_pkg::*; (
    input  wire logic [31:0] vaddr_i,
    input  wire logic [2:0]  k0_i,
    output seg_result_t      seg_o
);

    always_comb begin
        seg_o.paddr    = vaddr_i;
        seg_o.mapped   = 1'b1; // kuseg, ksseg and kseg3 go through the TLB
        seg_o.uncached = 1'b0;
        case (vaddr_i[31:29])
            SEG_KSEG0: begin
                seg_o.paddr    = {3'b000, vaddr_i[28:0]};
                seg_o.mapped   = 1'b0;
                seg_o.uncached = (k0_i == CACHE_UNCACHED);
            end
            SEG_KSEG1: begin
                seg_o.paddr    = {3'b000, vaddr_i[28:0]};
                seg_o.mapped   = 1'b0;
                seg_o.uncached = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [15:0] mask;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic [19:0] pfn;
        logic        miss;
        logic        valid;
        logic        dirty;
        logic        uncached;
    } tlb_result_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        mapped;
        logic        uncached;
    } seg_result_t;

    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    localparam logic [2:0] CACHE_UNCACHED = 3'd2;

endpackage

`default_nettype wire

/* hdl/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    // Register number in the upper five bits, select in the lower three
    typedef enum logic [7:0] {
        CP0_INDEX    = 8'h00,
        CP0_RANDOM   = 8'h08,
        CP0_ENTRYLO0 = 8'h10,
        CP0_ENTRYLO1 = 8'h18,
        CP0_CONTEXT  = 8'h20,
        CP0_PAGEMASK = 8'h28,
        CP0_WIRED    = 8'h30,
        CP0_BADVADDR = 8'h40,
        CP0_COUNT    = 8'h48,
        CP0_ENTRYHI  = 8'h50,
        CP0_COMPARE  = 8'h58,
        CP0_STATUS   = 8'h60,
        CP0_CAUSE    = 8'h68,
        CP0_EPC      = 8'h70,
        CP0_PRID     = 8'h78,
        CP0_EBASE    = 8'h79,
        CP0_CONFIG0  = 8'h80,
        CP0_CONFIG1  = 8'h81
    } cp0_addr_e;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    typedef struct packed {
        logic        valid;
        logic        bd;
        logic [31:0] epc;
        exc_code_e   code;
        logic [31:0] badvaddr;
        logic        badvaddr_we;
    } exc_req_t;

    localparam logic [31:0] INIT_STATUS = 32'h0040_0000; // BEV set
    localparam logic [31:0] INIT_PRID   = 32'h0001_8003;
    localparam logic [31:0] INIT_EBASE  = 32'h8000_0000;
    localparam logic [31:0] INIT_CONF0  = 32'h8000_0083; // TLB MMU, K0 cacheable
    localparam logic [31:0] INIT_CONF1  = 32'h0E00_0000; // Eight TLB entries

    localparam logic [31:0] MASK_INDEX    = 32'h0000_0007;
    localparam logic [31:0] MASK_ENTRYLO0 = 32'h03FF_FFFF;
    localparam logic [31:0] MASK_ENTRYLO1 = 32'h03FF_FFFF;
    localparam logic [31:0] MASK_CONTEXT  = 32'hFF80_0000;
    localparam logic [31:0] MASK_PAGEMASK = 32'h1FFF_E000;
    localparam logic [31:0] MASK_WIRED    = 32'h0000_0007;
    localparam logic [31:0] MASK_COUNT    = 32'hFFFF_FFFF;
    localparam logic [31:0] MASK_ENTRYHI  = 32'hFFFF_E0FF;
    localparam logic [31:0] MASK_COMPARE  = 32'hFFFF_FFFF;
    localparam logic [31:0] MASK_STATUS   = 32'h1040_FF13;
    localparam logic [31:0] MASK_CAUSE    = 32'h0080_0300;
    localparam logic [31:0] MASK_EPC      = 32'hFFFF_FFFF;
    localparam logic [31:0] MASK_EBASE    = 32'h3FFF_F000;
    localparam logic [31:0] MASK_CONF0    = 32'h0000_0007;

endpackage

`default_nettype wire
